//--- common/decodePkg.sv
// shared widths, register constants and control encodings for the decode stage
// encodings must match what the execute stage expects on each control bus
// opcode groups follow instruction bits 15:13, so reordering them breaks decode
package decodePkg;

   localparam int dataWidthC    = 16; // one data word
   localparam int regAddrWidthC = 3;  // register index width
   localparam int numRegsC      = 8;  // r0..r7

   localparam logic [regAddrWidthC-1:0] linkRegC = 3'd7; // JAL/JALR write pc+2 here

   localparam int imm1WidthC = 5;  // I-1 immediate, bits 4:0
   localparam int imm2WidthC = 8;  // I-2 immediate, bits 7:0
   localparam int jumpWidthC = 11; // jump displacement, bits 10:0

   // major opcode, instruction bits 15:13
   typedef enum logic [2:0] {
      grpHalt     = 3'b000, // halt / nop
      grpJump     = 3'b001, // J, JR, JAL, JALR
      grpArithImm = 3'b010, // ADDI, SUBI, XORI, ANDNI
      grpBranch   = 3'b011, // BEQZ, BNEZ, BLTZ, BGEZ
      grpMemory   = 3'b100, // ST, LD, SLBI, STU
      grpShiftImm = 3'b101, // ROLI, SLLI, RORI, SRLI
      grpRegOp    = 3'b110, // LBI, BTR, R-type shift and arith
      grpCompare  = 3'b111  // SEQ, SLT, SLE, SCO
   } opGroupT;

   // alu operation
   typedef enum logic [2:0] {
      aluRotl = 3'b000,
      aluShl  = 3'b001,
      aluRotr = 3'b010,
      aluShr  = 3'b011,
      aluAdd  = 3'b100,
      aluAnd  = 3'b101,
      aluOr   = 3'b110,
      aluXor  = 3'b111
   } aluOpT;

   // alu B operand source
   typedef enum logic [1:0] {
      bSrcRegB     = 2'b00, // second read port
      bSrcImm      = 2'b01, // extended immediate
      bSrcJumpBase = 2'b10  // jump register base path
   } bSrcT;

   // write-back source
   typedef enum logic [1:0] {
      regSrcPcLink = 2'b00, // pc + 2
      regSrcMemory = 2'b01, // load data
      regSrcAlu    = 2'b10, // alu result
      regSrcImm    = 2'b11  // immediate straight through
   } regSrcT;

   // branch condition tested on rs
   typedef enum logic [1:0] {
      brEqz = 2'b00,
      brNez = 2'b01,
      brLtz = 2'b10,
      brGez = 2'b11
   } branchCmdT;

   // which field names the write register
   typedef enum logic [1:0] {
      dstRt   = 2'b00, // bits 7:5
      dstRs   = 2'b01, // bits 10:8
      dstRd   = 2'b10, // bits 4:2
      dstLink = 2'b11  // fixed r7
   } regDstT;

endpackage

//--- decode/ctrlDecoder.sv
// opcode and function decode for the 16-bit eight-register core
// purely combinational; every output follows instruction in the same cycle
// compare group (SEQ/SLT/SLE/SCO) decodes to all-inactive controls
// STU sits at memory function 11, BEQZ gets branch condition eqz
// imm1/imm2 are zero-extended only for XORI, ANDNI and SLBI
`timescale 1ns/1ns

module ctrlDecoder import decodePkg::*; (
   input  logic [dataWidthC-1:0]    instruction,
   output aluOpT                    aluOp,
   output bSrcT                     bSrc,
   output logic                     invA,
   output logic                     invB,
   output logic                     memWrite,
   output logic                     aluJump,
   output logic                     pcOrAdd,
   output logic                     slbi,
   output logic                     btr,
   output logic                     branching,
   output regSrcT                   regSrc,
   output branchCmdT                branchCmd,
   output logic                     regWrite,
   output logic [regAddrWidthC-1:0] writeSel,
   output logic [dataWidthC-1:0]    imm1,
   output logic [dataWidthC-1:0]    imm2,
   output logic [dataWidthC-1:0]    jumpDisp
);

   opGroupT    opGroup;  // bits 15:13
   logic [1:0] subOp;    // bits 12:11
   logic [1:0] funct;    // bits 1:0, R-type only
   regDstT     regDst;   // write register field select
   logic       zeroExt;  // immediates zero- rather than sign-extended

   assign opGroup = opGroupT'(instruction[15:13]);
   assign subOp   = instruction[12:11];
   assign funct   = instruction[1:0];

   always_comb begin
      // everything inactive unless a group below claims it
      aluOp     = aluRotl;
      bSrc      = bSrcRegB;
      invA      = 1'b0;
      invB      = 1'b0;
      memWrite  = 1'b0;
      aluJump   = 1'b0;
      pcOrAdd   = 1'b0;
      slbi      = 1'b0;
      btr       = 1'b0;
      branching = 1'b0;
      regSrc    = regSrcPcLink;
      branchCmd = brEqz;
      regWrite  = 1'b0;
      regDst    = dstRt;
      zeroExt   = 1'b0;

      case (opGroup)
         grpHalt: begin
            // halt leaves all controls at their defaults
         end

         grpArithImm: begin          // rt <- rs op imm1
            regWrite = 1'b1;
            bSrc     = bSrcImm;
            regSrc   = regSrcAlu;
            case (subOp)
               2'b00: aluOp = aluAdd; // ADDI
               2'b01: begin           // SUBI, imm - rs
                  aluOp = aluAdd;
                  invA  = 1'b1;
               end
               2'b10: begin           // XORI
                  aluOp   = aluXor;
                  zeroExt = 1'b1;
               end
               default: begin         // ANDNI, rs & ~imm
                  aluOp   = aluAnd;
                  invB    = 1'b1;
                  zeroExt = 1'b1;
               end
            endcase
         end

         grpShiftImm: begin          // amount from low 4 bits of imm1
            regWrite = 1'b1;
            bSrc     = bSrcImm;
            regSrc   = regSrcAlu;
            case (subOp)
               2'b00:   aluOp = aluRotl; // ROLI
               2'b01:   aluOp = aluShl;  // SLLI
               2'b10:   aluOp = aluRotr; // RORI
               default: aluOp = aluShr;  // SRLI
            endcase
         end

         grpMemory: begin
            aluOp = aluAdd;          // address is rs + imm1
            bSrc  = bSrcImm;
            case (subOp)
               2'b00: memWrite = 1'b1; // ST, data from rt port
               2'b01: begin            // LD into rt
                  regWrite = 1'b1;
                  regSrc   = regSrcMemory;
               end
               2'b10: begin            // SLBI, rs <- (rs << 8) | imm2
                  aluOp    = aluOr;
                  bSrc     = bSrcRegB; // execute picks imm2 itself when slbi is set
                  slbi     = 1'b1;
                  zeroExt  = 1'b1;
                  regWrite = 1'b1;
                  regSrc   = regSrcAlu;
                  regDst   = dstRs;
               end
               default: begin          // STU, store then rs <- address
                  memWrite = 1'b1;
                  regWrite = 1'b1;
                  regSrc   = regSrcAlu;
                  regDst   = dstRs;
               end
            endcase
         end

         grpRegOp: begin
            regWrite = 1'b1;
            regDst   = dstRd;        // R-type result goes to bits 4:2
            regSrc   = regSrcAlu;
            case (subOp)
               2'b00: begin          // LBI, rs <- sign-extended imm2
                  bSrc   = bSrcImm;
                  regSrc = regSrcImm;
                  regDst = dstRs;
               end
               2'b01: btr = 1'b1;    // BTR, bit reverse of rs
               2'b10: begin          // shift by low 4 bits of rt
                  case (funct)
                     2'b00:   aluOp = aluRotl; // ROL
                     2'b01:   aluOp = aluShl;  // SLL
                     2'b10:   aluOp = aluRotr; // ROR
                     default: aluOp = aluShr;  // SRL
                  endcase
               end
               default: begin
                  case (funct)
                     2'b00: aluOp = aluAdd; // ADD
                     2'b01: begin           // SUB, rt - rs
                        aluOp = aluAdd;
                        invA  = 1'b1;
                     end
                     2'b10: aluOp = aluXor; // XOR
                     default: begin         // ANDN, rs & ~rt
                        aluOp = aluAnd;
                        invB  = 1'b1;
                     end
                  endcase
               end
            endcase
         end

         grpCompare: begin
            // compare group is not supported, no controls raised
         end

         grpBranch: begin            // target is pc + 2 + imm2
            aluOp     = aluAdd;
            branching = 1'b1;
            case (subOp)
               2'b00: branchCmd = brEqz; // BEQZ
               2'b01: branchCmd = brNez; // BNEZ
               2'b10: begin              // BLTZ
                  branchCmd = brLtz;
                  invB      = 1'b1;
               end
               default: begin            // BGEZ
                  branchCmd = brGez;
                  invB      = 1'b1;
               end
            endcase
         end

         grpJump: begin
            aluOp = aluAdd;
            case (subOp)
               2'b00: pcOrAdd = 1'b1;  // J, pc + 2 + jumpDisp
               2'b01: begin            // JR, pc <- rs + imm2
                  bSrc    = bSrcJumpBase;
                  aluJump = 1'b1;
               end
               2'b10: begin            // JAL, also r7 <- pc + 2
                  pcOrAdd  = 1'b1;
                  regWrite = 1'b1;
                  regDst   = dstLink;
               end
               default: begin          // JALR
                  bSrc     = bSrcJumpBase;
                  aluJump  = 1'b1;
                  regWrite = 1'b1;
                  regDst   = dstLink;
               end
            endcase
         end

         default: begin
            // all eight groups are listed above
         end
      endcase
   end

   // write register field select
   always_comb begin
      case (regDst)
         dstRt:   writeSel = instruction[7:5];
         dstRs:   writeSel = instruction[10:8];
         dstRd:   writeSel = instruction[4:2];
         default: writeSel = linkRegC;
      endcase
   end

   // immediate extension
   assign imm1 = zeroExt
      ? {{(dataWidthC-imm1WidthC){1'b0}}, instruction[imm1WidthC-1:0]}
      : {{(dataWidthC-imm1WidthC){instruction[imm1WidthC-1]}}, instruction[imm1WidthC-1:0]};

   assign imm2 = zeroExt
      ? {{(dataWidthC-imm2WidthC){1'b0}}, instruction[imm2WidthC-1:0]}
      : {{(dataWidthC-imm2WidthC){instruction[imm2WidthC-1]}}, instruction[imm2WidthC-1:0]};

   // jump displacement is always signed
   assign jumpDisp = {{(dataWidthC-jumpWidthC){instruction[jumpWidthC-1]}},
                      instruction[jumpWidthC-1:0]};

endmodule

//--- decodeStage.f
+incdir+tests
common/decodePkg.sv
decode/ctrlDecoder.sv
regFile/regFile.sv
src/decodeStage.sv
tests/tbDecodeStage.sv

//--- regFile/regFile.sv
// eight 16-bit registers, two combinational reads, one clocked write
// a write at a clock edge is visible on the read ports only after that edge
// no write-to-read bypass within a cycle; r0 is an ordinary register
// asynchronous active-low reset clears every register
`timescale 1ns/1ns

module regFile import decodePkg::*; (
   input  logic                     clk,
   input  logic                     arstN,
   input  logic [regAddrWidthC-1:0] readSel1,  // rs field
   input  logic [regAddrWidthC-1:0] readSel2,  // rt field
   input  logic [regAddrWidthC-1:0] writeSel,
   input  logic [dataWidthC-1:0]    writeData,
   input  logic                     regWrite,
   output logic [dataWidthC-1:0]    readData1,
   output logic [dataWidthC-1:0]    readData2
);

   logic [dataWidthC-1:0] regs [numRegsC]; // register array

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < numRegsC; i++) begin
            regs[i] <= '0;               // all registers start at zero
         end
      end else if (regWrite) begin
         regs[writeSel] <= writeData;    // single write port
      end
   end

   // read muxes, no bypass from writeData
   assign readData1 = regs[readSel1];
   assign readData2 = regs[readSel2];

endmodule

//--- runSim.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
# build output goes to build.log, simulation output to sim.log
# exit status is nonzero on a build error or when the log holds the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f decodeStage.f \
   --top-module tbDecodeStage \
   -Mdir obj_dir \
   -o simDecodeStage > build.log 2>&1 \
   && ./obj_dir/simDecodeStage > sim.log 2>&1 \
   || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "STATUS: FAIL" sim.log \
   && { echo "simulation reported failure, see sim.log"; exit 1; } \
   || { echo "simulation passed"; exit 0; }

//--- src/decodeStage.sv
// decode stage top: control decoder plus register file
// combinational except for the register write at the rising clock edge
// writeData belongs to the write-back instruction of the same cycle
// no stall input; the caller holds instruction or feeds a halt encoding
// read ports always address rs (bits 10:8) and rt (bits 7:5)
`timescale 1ns/1ns

module decodeStage import decodePkg::*; (
   input  logic                  clk,
   input  logic                  arstN,
   input  logic [dataWidthC-1:0] instruction,  // from fetch
   input  logic [dataWidthC-1:0] writeData,    // from write-back
   output logic [dataWidthC-1:0] readData1,    // rs value
   output logic [dataWidthC-1:0] readData2,    // rt value
   output logic [dataWidthC-1:0] imm1,
   output logic [dataWidthC-1:0] imm2,
   output logic [dataWidthC-1:0] jumpDisp,
   output aluOpT                 aluOp,
   output bSrcT                  bSrc,
   output logic                  invA,
   output logic                  invB,
   output logic                  memWrite,
   output logic                  aluJump,
   output logic                  pcOrAdd,
   output logic                  slbi,
   output logic                  btr,
   output logic                  branching,
   output regSrcT                regSrc,
   output branchCmdT             branchCmd
);

   logic                     regWrite; // decoder to register file
   logic [regAddrWidthC-1:0] writeSel;

   ctrlDecoder u_ctrlDecoder (
      .instruction (instruction),
      .aluOp       (aluOp),
      .bSrc        (bSrc),
      .invA        (invA),
      .invB        (invB),
      .memWrite    (memWrite),
      .aluJump     (aluJump),
      .pcOrAdd     (pcOrAdd),
      .slbi        (slbi),
      .btr         (btr),
      .branching   (branching),
      .regSrc      (regSrc),
      .branchCmd   (branchCmd),
      .regWrite    (regWrite),
      .writeSel    (writeSel),
      .imm1        (imm1),
      .imm2        (imm2),
      .jumpDisp    (jumpDisp)
   );

   regFile u_regFile (
      .clk       (clk),
      .arstN     (arstN),
      .readSel1  (instruction[10:8]), // rs
      .readSel2  (instruction[7:5]),  // rt
      .writeSel  (writeSel),
      .writeData (writeData),
      .regWrite  (regWrite),
      .readData1 (readData1),
      .readData2 (readData2)
   );

endmodule

//--- tests/decodeTable.svh
// decode table, one row per kept instruction plus halt and the compare group
// columns: name, opcode bits 15:11, funct bits 1:0 (-1 keeps them random),
//          control vector, writes a register, write-register field, zero-extended imm
// control vector is {aluOp, bSrc, invA invB memWrite aluJump pcOrAdd slbi btr branching,
//                    regSrc, branchCmd}
// included inside the testbench module, which provides addRow
`ifndef DECODE_TABLE_SVH
`define DECODE_TABLE_SVH

function automatic void buildTable();
   //      name     opcode    funct  aluOp_bSrc_flags_regSrc_br   wr    dst      zext
   addRow("HALT",  5'b00000, -1, 17'b000_00_00000000_00_00, 1'b0, dstRt,   1'b0);
   addRow("J",     5'b00100, -1, 17'b100_00_00001000_00_00, 1'b0, dstRt,   1'b0);
   addRow("JR",    5'b00101, -1, 17'b100_10_00010000_00_00, 1'b0, dstRt,   1'b0);
   addRow("JAL",   5'b00110, -1, 17'b100_00_00001000_00_00, 1'b1, dstLink, 1'b0);
   addRow("JALR",  5'b00111, -1, 17'b100_10_00010000_00_00, 1'b1, dstLink, 1'b0);
   addRow("ADDI",  5'b01000, -1, 17'b100_01_00000000_10_00, 1'b1, dstRt,   1'b0);
   addRow("SUBI",  5'b01001, -1, 17'b100_01_10000000_10_00, 1'b1, dstRt,   1'b0);
   addRow("XORI",  5'b01010, -1, 17'b111_01_00000000_10_00, 1'b1, dstRt,   1'b1);
   addRow("ANDNI", 5'b01011, -1, 17'b101_01_01000000_10_00, 1'b1, dstRt,   1'b1);
   addRow("BEQZ",  5'b01100, -1, 17'b100_00_00000001_00_00, 1'b0, dstRt,   1'b0); // eqz
   addRow("BNEZ",  5'b01101, -1, 17'b100_00_00000001_00_01, 1'b0, dstRt,   1'b0);
   addRow("BLTZ",  5'b01110, -1, 17'b100_00_01000001_00_10, 1'b0, dstRt,   1'b0);
   addRow("BGEZ",  5'b01111, -1, 17'b100_00_01000001_00_11, 1'b0, dstRt,   1'b0);
   addRow("ST",    5'b10000, -1, 17'b100_01_00100000_00_00, 1'b0, dstRt,   1'b0);
   addRow("LD",    5'b10001, -1, 17'b100_01_00000000_01_00, 1'b1, dstRt,   1'b0);
   addRow("SLBI",  5'b10010, -1, 17'b110_00_00000100_10_00, 1'b1, dstRs,   1'b1);
   addRow("STU",   5'b10011, -1, 17'b100_01_00100000_10_00, 1'b1, dstRs,   1'b0); // func 11
   addRow("ROLI",  5'b10100, -1, 17'b000_01_00000000_10_00, 1'b1, dstRt,   1'b0);
   addRow("SLLI",  5'b10101, -1, 17'b001_01_00000000_10_00, 1'b1, dstRt,   1'b0);
   addRow("RORI",  5'b10110, -1, 17'b010_01_00000000_10_00, 1'b1, dstRt,   1'b0);
   addRow("SRLI",  5'b10111, -1, 17'b011_01_00000000_10_00, 1'b1, dstRt,   1'b0);
   addRow("LBI",   5'b11000, -1, 17'b000_01_00000000_11_00, 1'b1, dstRs,   1'b0);
   addRow("BTR",   5'b11001, -1, 17'b000_00_00000010_10_00, 1'b1, dstRd,   1'b0);
   addRow("ROL",   5'b11010,  0, 17'b000_00_00000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("SLL",   5'b11010,  1, 17'b001_00_00000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("ROR",   5'b11010,  2, 17'b010_00_00000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("SRL",   5'b11010,  3, 17'b011_00_00000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("ADD",   5'b11011,  0, 17'b100_00_00000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("SUB",   5'b11011,  1, 17'b100_00_10000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("XOR",   5'b11011,  2, 17'b111_00_00000000_10_00, 1'b1, dstRd,   1'b0);
   addRow("ANDN",  5'b11011,  3, 17'b101_00_01000000_10_00, 1'b1, dstRd,   1'b0);
   // compare group decodes to nothing
   addRow("SEQ",   5'b11100, -1, 17'b000_00_00000000_00_00, 1'b0, dstRt,   1'b0);
   addRow("SLT",   5'b11101, -1, 17'b000_00_00000000_00_00, 1'b0, dstRt,   1'b0);
   addRow("SLE",   5'b11110, -1, 17'b000_00_00000000_00_00, 1'b0, dstRt,   1'b0);
   addRow("SCO",   5'b11111, -1, 17'b000_00_00000000_00_00, 1'b0, dstRt,   1'b0);
endfunction

`endif

//--- tests/tbDecodeStage.sv
// testbench for the decode stage: table-driven control decode, immediate
// extension and register writes, checked against a shadow register model
// register fields and write data come from an xorshift generator, fixed seed
// each table row is applied several times with fresh random fields
// a cycle watchdog bounds the run
`timescale 1ns/1ns

module tbDecodeStage import decodePkg::*; ();

   localparam int halfPeriodC  = 20;   // 40 ns clock
   localparam int resetCyclesC = 16;
   localparam int repsC        = 3;    // random variants per table row
   localparam int maxCyclesC   = 1000; // watchdog limit

   logic                  clk;
   logic                  arstN;
   logic [dataWidthC-1:0] instruction;
   logic [dataWidthC-1:0] writeData;
   logic [dataWidthC-1:0] readData1;
   logic [dataWidthC-1:0] readData2;
   logic [dataWidthC-1:0] imm1;
   logic [dataWidthC-1:0] imm2;
   logic [dataWidthC-1:0] jumpDisp;
   aluOpT                 aluOp;
   bSrcT                  bSrc;
   logic                  invA;
   logic                  invB;
   logic                  memWrite;
   logic                  aluJump;
   logic                  pcOrAdd;
   logic                  slbi;
   logic                  btr;
   logic                  branching;
   regSrcT                regSrc;
   branchCmdT             branchCmd;

   // table columns, filled by buildTable
   string       nameQ[$];
   logic [4:0]  opcodeQ[$];
   int          functQ[$];  // -1 leaves bits 1:0 random
   logic [16:0] ctrlQ[$];
   logic        writesQ[$];
   regDstT      dstQ[$];
   logic        zextQ[$];

   logic [dataWidthC-1:0] shadow [numRegsC]; // register model
   logic [31:0]           rngState;
   int                    checkCount;
   int                    errorCount;
   logic                  finished = 1'b0; // set once the last check is done

   decodeStage u_decodeStage (
      .clk         (clk),
      .arstN       (arstN),
      .instruction (instruction),
      .writeData   (writeData),
      .readData1   (readData1),
      .readData2   (readData2),
      .imm1        (imm1),
      .imm2        (imm2),
      .jumpDisp    (jumpDisp),
      .aluOp       (aluOp),
      .bSrc        (bSrc),
      .invA        (invA),
      .invB        (invB),
      .memWrite    (memWrite),
      .aluJump     (aluJump),
      .pcOrAdd     (pcOrAdd),
      .slbi        (slbi),
      .btr         (btr),
      .branching   (branching),
      .regSrc      (regSrc),
      .branchCmd   (branchCmd)
   );

   always #halfPeriodC clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] nextRandom();
      rngState = xorshift32(rngState);
      return rngState;
   endfunction

   function automatic void addRow(input string name, input logic [4:0] opcode,
                                  input int funct, input logic [16:0] ctrl,
                                  input logic writes, input regDstT dst, input logic zext);
      nameQ.push_back(name);
      opcodeQ.push_back(opcode);
      functQ.push_back(funct);
      ctrlQ.push_back(ctrl);
      writesQ.push_back(writes);
      dstQ.push_back(dst);
      zextQ.push_back(zext);
   endfunction

   `include "decodeTable.svh"

   // same bit order as the table's control vector
   function automatic logic [16:0] ctrlActual();
      return {aluOp, bSrc, invA, invB, memWrite, aluJump, pcOrAdd, slbi, btr, branching,
              regSrc, branchCmd};
   endfunction

   function automatic logic [15:0] extendImm1(input logic [4:0] v, input logic zext);
      return zext ? {11'b0, v} : {{11{v[4]}}, v};
   endfunction

   function automatic logic [15:0] extendImm2(input logic [7:0] v, input logic zext);
      return zext ? {8'b0, v} : {{8{v[7]}}, v};
   endfunction

   function automatic logic [2:0] destReg(input logic [15:0] instr, input regDstT dst);
      logic [2:0] sel;
      case (dst)
         dstRt:   sel = instr[7:5];
         dstRs:   sel = instr[10:8];
         dstRd:   sel = instr[4:2];
         default: sel = 3'd7;  // link register r7
      endcase
      return sel;
   endfunction

   task automatic checkValue(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      assert (actual === expected) else begin
         errorCount++;
         $display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
      end
   endtask

   // halt with rs/rt set, random writeData that must not land; posedge+2 to posedge+2
   task automatic haltReadCheck(input string testName, input logic [2:0] rs,
                                input logic [2:0] rt);
      logic [31:0] rnd;
      rnd = nextRandom();
      instruction = {5'b00000, rs, rt, 5'b00000};
      writeData   = rnd[15:0];
      @(negedge clk);                   // outputs settled mid cycle
      checkValue($sformatf("%s halt ctrl", testName), 32'd0, 32'(ctrlActual()));
      checkValue($sformatf("%s r%0d port1", testName, rs), 32'(shadow[rs]), 32'(readData1));
      checkValue($sformatf("%s r%0d port2", testName, rt), 32'(shadow[rt]), 32'(readData2));
      @(posedge clk);
      #2;
   endtask

   task automatic applyRow(input int r);
      logic [31:0] rnd;
      logic [15:0] instr;
      logic [15:0] data;
      logic [2:0]  target;
      int          funct;
      rnd   = nextRandom();
      instr = {opcodeQ[r], rnd[10:0]}; // register fields random
      funct = functQ[r];
      if (funct >= 0) begin
         instr[1:0] = funct[1:0];      // R-type function bits
      end
      rnd         = nextRandom();
      data        = rnd[15:0];
      instruction = instr;
      writeData   = data;
      @(negedge clk);
      checkValue($sformatf("%s ctrl", nameQ[r]), 32'(ctrlQ[r]), 32'(ctrlActual()));
      checkValue($sformatf("%s imm1", nameQ[r]), 32'(extendImm1(instr[4:0], zextQ[r])),
                 32'(imm1));
      checkValue($sformatf("%s imm2", nameQ[r]), 32'(extendImm2(instr[7:0], zextQ[r])),
                 32'(imm2));
      checkValue($sformatf("%s jumpDisp", nameQ[r]), 32'({{5{instr[10]}}, instr[10:0]}),
                 32'(jumpDisp));
      // old contents, no bypass of this cycle's write
      checkValue($sformatf("%s rs read", nameQ[r]), 32'(shadow[instr[10:8]]), 32'(readData1));
      checkValue($sformatf("%s rt read", nameQ[r]), 32'(shadow[instr[7:5]]), 32'(readData2));
      @(posedge clk);                  // write edge
      target = destReg(instr, dstQ[r]);
      if (writesQ[r]) begin
         shadow[target] = data;
      end
      #2;
      haltReadCheck($sformatf("%s readback", nameQ[r]), target, rnd[18:16]);
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < maxCyclesC && !finished) begin
         @(posedge clk);
         cycles++;
      end
      if (!finished) begin
         $display("timeout: test did not finish within %0d cycles", maxCyclesC);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin : stimulus
      clk         = 1'b0;
      arstN       = 1'b0;
      instruction = '0;                 // halt
      writeData   = '0;
      rngState    = 32'h9178cba3;
      checkCount  = 0;
      errorCount  = 0;
      for (int i = 0; i < numRegsC; i++) begin
         shadow[3'(i)] = '0;
      end
      buildTable();
      repeat (resetCyclesC) @(posedge clk);
      #2;
      arstN = 1'b1;
      for (int i = 0; i < numRegsC; i++) begin
         haltReadCheck("after reset", 3'(i), 3'(numRegsC - 1 - i));
      end
      for (int r = 0; r < nameQ.size(); r++) begin
         for (int k = 0; k < repsC; k++) begin
            applyRow(r);
         end
      end
      // every register must match the model, catches stray writes
      for (int i = 0; i < numRegsC; i++) begin
         haltReadCheck("final sweep", 3'(i), 3'(numRegsC - 1 - i));
      end
      finished = 1'b1;
      $display("checks %0d errors %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
